//--- compile.f
+incdir+common
common/fir_pkg.sv
common/fas_regs_pkg.sv
fir/fir_delay_line.sv
fir/fir_mac.sv
fir/fir_coef_regs.sv
hdl/fas_top.sv
tb/tb_clkgen.sv
tb/tb_fas.sv

//--- run.sh
#!/bin/sh
# build and run the FIR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fas -f compile.f

# the simulator exits non-zero on a failed check, the search below decides
out=$(./obj_dir/Vtb_fas 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

//--- tb/tb_fas.sv
`default_nettype none

`include "fas_macros.svh"

module tb_fas;

    import fir_pkg::*;
    import fas_regs_pkg::*;

    localparam int READY_TIMEOUT = 16;
    localparam int DRAIN_TIMEOUT = 64;
    localparam logic [`FAS_APB_AW-1:0] COEF_END = `FAS_APB_AW'(4 * `FAS_HALF_TAPS);

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_PUSH,
        OP_IDLE
    } op_e;

    // data is write data, expected read data, a sample or an idle count
    typedef struct {
        op_e                    op;
        logic [`FAS_APB_AW-1:0] addr;
        apb_data_t              data;
        logic                   err;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`FAS_APB_AW-1:0] paddr;
    apb_data_t              pwdata;
    apb_data_t              prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   data_valid;
    sample_t                data_in;
    sample_t                fir_d;
    logic                   fir_valid;

    row_t        rows[$];
    logic [31:0] rng_state;
    int          cyc;

    // reference model state
    shortint     coef_m[`FAS_HALF_TAPS];
    shortint     hist_m[`FAS_TAPS];
    logic        en_m;
    int          fill_m;
    sample_t     exp_q[$];
    int          exp_cyc_q[$];

    tb_clkgen u_clk (.clk_o(clk));

    fas_top uut (
        .clk          (clk),
        .rst          (rst),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr),
        .data_valid_i (data_valid),
        .data_i       (data_in),
        .fir_d_o      (fir_d),
        .fir_valid_o  (fir_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // pre-add mirrored taps, MAC, shift by 16 and add the sign bit
    function automatic sample_t filter_reference();
        longint acc;
        longint shifted;
        acc = 0;
        for (int k = 0; k < `FAS_HALF_TAPS; k++) begin
            acc += (longint'(hist_m[k]) + longint'(hist_m[`FAS_TAPS-1-k])) * longint'(coef_m[k]);
        end
        shifted = acc >>> `FAS_ZOOM;
        if (acc < 0) begin
            shifted = shifted + 1;
        end
        return sample_t'(shifted[`FAS_BW-1:0]);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH at time %0t: %s is %0h, expected %0h",
                                    $time, what, got, exp));
        end
    endtask

    // each valid pulse takes the oldest queued result and its cycle
    task automatic check_outputs();
        sample_t exp_d;
        int      exp_cyc;
        if ($isunknown(fir_valid)) begin
            stop_on_error("fir_valid_o is unknown outside reset");
        end
        if (fir_valid) begin
            if (exp_q.size() == 0) begin
                stop_on_error("fir_valid_o went high with no result expected");
            end
            exp_d   = exp_q.pop_front();
            exp_cyc = exp_cyc_q.pop_front();
            check_value("fir_d_o", 32'(fir_d), 32'(exp_d));
            check_value("fir_valid_o cycle", cyc, exp_cyc);
        end else if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cyc) begin
            stop_on_error("fir_valid_o did not rise two edges after the accept");
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        cyc++;
        if (!rst) begin
            check_outputs();
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        #1;
        while (pready !== 1'b1) begin
            if (n >= READY_TIMEOUT) begin
                stop_on_error("APB transfer got no pready within the timeout");
            end
            n++;
            next_cycle();
            #1;
        end
    endtask

    task automatic mirror_write(input logic [`FAS_APB_AW-1:0] addr, input apb_data_t data);
        if (addr < COEF_END && addr[1:0] == 2'b00) begin
            coef_m[addr[5:2]] = shortint'(data[`FAS_BW-1:0]);
        end else if (addr == CTRL_ADDR) begin
            en_m = data[0];
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [`FAS_APB_AW-1:0] addr,
                                input apb_data_t data, input logic exp_err);
        next_cycle();
        data_valid = 1'b0;
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = write;
        paddr      = addr;
        pwdata     = write ? data : '0;
        next_cycle();
        penable = 1'b1;
        wait_ready();
        check_value("pslverr_o", 32'(pslverr), 32'(exp_err));
        if (write) begin
            mirror_write(addr, data);
        end else begin
            check_value("prdata_o", prdata, data);
        end
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic push_sample(input sample_t s);
        next_cycle();
        psel       = 1'b0;
        penable    = 1'b0;
        data_valid = 1'b1;
        data_in    = s;
        // enable gates intake in the model too
        if (en_m) begin
            for (int i = `FAS_TAPS - 1; i > 0; i--) begin
                hist_m[i] = hist_m[i-1];
            end
            hist_m[0] = shortint'(s);
            if (fill_m < `FAS_TAPS) begin
                fill_m++;
            end
            if (fill_m == `FAS_TAPS) begin
                exp_q.push_back(filter_reference());
                exp_cyc_q.push_back(cyc + 2);
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            data_valid = 1'b0;
            psel       = 1'b0;
            penable    = 1'b0;
        end
    endtask

    task automatic run_row(input row_t r);
        case (r.op)
            OP_WRITE: apb_transfer(1'b1, r.addr, r.data, r.err);
            OP_READ:  apb_transfer(1'b0, r.addr, r.data, r.err);
            OP_PUSH:  push_sample(sample_t'(r.data[`FAS_BW-1:0]));
            default:  idle_cycles(int'(r.data));
        endcase
    endtask

    task automatic append_row(input op_e op, input logic [`FAS_APB_AW-1:0] addr,
                              input apb_data_t data, input logic err);
        row_t r;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.err  = err;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] r;
        // all registers read zero after reset
        for (int k = 0; k < `FAS_HALF_TAPS; k++) begin
            append_row(OP_READ, `FAS_APB_AW'(4 * k), 32'h0, 1'b0);
        end
        append_row(OP_READ, CTRL_ADDR, 32'h0, 1'b0);
        append_row(OP_IDLE, 8'h00, 32'd10, 1'b0);

        // negative values read back sign-extended
        append_row(OP_WRITE, 8'h00, 32'h0000_1234, 1'b0);
        append_row(OP_WRITE, 8'h14, 32'h0000_8001, 1'b0);
        append_row(OP_WRITE, 8'h3c, 32'hABCD_FFFF, 1'b0);
        append_row(OP_READ, 8'h00, 32'h0000_1234, 1'b0);
        append_row(OP_READ, 8'h14, 32'hFFFF_8001, 1'b0);
        append_row(OP_READ, 8'h3c, 32'hFFFF_FFFF, 1'b0);
        append_row(OP_WRITE, CTRL_ADDR, 32'h0000_0001, 1'b0);
        append_row(OP_READ, CTRL_ADDR, 32'h0000_0001, 1'b0);
        append_row(OP_WRITE, CTRL_ADDR, 32'hFFFF_FFFE, 1'b0);
        append_row(OP_READ, CTRL_ADDR, 32'h0000_0000, 1'b0);

        // unmapped and misaligned accesses leave state alone
        append_row(OP_WRITE, 8'h80, 32'h0000_7777, 1'b1);
        append_row(OP_READ, 8'h80, 32'h0, 1'b1);
        append_row(OP_WRITE, 8'h06, 32'h0000_5555, 1'b1);
        append_row(OP_READ, 8'h04, 32'h0, 1'b0);
        append_row(OP_READ, 8'h00, 32'h0000_1234, 1'b0);
        append_row(OP_READ, CTRL_ADDR, 32'h0, 1'b0);

        // intake disabled
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            append_row(OP_PUSH, 8'h00, 32'(r[15:0]), 1'b0);
        end
        append_row(OP_IDLE, 8'h00, 32'd6, 1'b0);

        // warm-up, first result on the 32nd accept
        append_row(OP_WRITE, CTRL_ADDR, 32'h0000_0001, 1'b0);
        for (int i = 0; i < 31; i++) begin
            r = next_random();
            append_row(OP_PUSH, 8'h00, 32'(r[15:0]), 1'b0);
        end
        append_row(OP_IDLE, 8'h00, 32'd5, 1'b0);
        for (int i = 0; i < 9; i++) begin
            r = next_random();
            append_row(OP_PUSH, 8'h00, 32'(r[15:0]), 1'b0);
        end
        append_row(OP_IDLE, 8'h00, 32'd4, 1'b0);

        // impulse response, upper write bits are ignored
        for (int k = 0; k < `FAS_HALF_TAPS; k++) begin
            r = next_random();
            append_row(OP_WRITE, `FAS_APB_AW'(4 * k), r, 1'b0);
            if (k == 7) begin
                append_row(OP_READ, 8'h1c, {{16{r[15]}}, r[15:0]}, 1'b0);
            end
        end
        for (int i = 0; i < 65; i++) begin
            append_row(OP_PUSH, 8'h00, (i == 32) ? 32'h0000_4000 : 32'h0, 1'b0);
        end
        append_row(OP_IDLE, 8'h00, 32'd4, 1'b0);

        // random stream with gaps, bursts and a rewrite halfway
        for (int i = 0; i < 200; i++) begin
            if (i == 100) begin
                for (int k = 0; k < `FAS_HALF_TAPS; k += 5) begin
                    r = next_random();
                    append_row(OP_WRITE, `FAS_APB_AW'(4 * k), r, 1'b0);
                end
            end
            r = next_random();
            append_row(OP_PUSH, 8'h00, 32'(r[15:0]), 1'b0);
            if (r[31:29] >= 3'd5) begin
                append_row(OP_IDLE, 8'h00, 32'(r[27:26]) + 32'd1, 1'b0);
            end
        end
        append_row(OP_IDLE, 8'h00, 32'd4, 1'b0);
    endtask

    initial begin
        int n;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        data_valid = 1'b0;
        data_in    = '0;
        rng_state  = 32'h659743fe;
        cyc        = 0;
        en_m       = 1'b0;
        fill_m     = 0;
        build_table();

        for (int i = 0; i < 8; i++) begin
            next_cycle();
        end
        rst = 1'b0;

        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        idle_cycles(1);
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
            next_cycle();
            n++;
        end
        // quiet tail catches stray pulses
        idle_cycles(4);
        if (exp_q.size() != 0) begin
            stop_on_error("timed out waiting for the remaining filter outputs");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fas_top.sv
`default_nettype none

`include "fas_macros.svh"

module fas_top (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             psel_i,
    input  wire                             penable_i,
    input  wire                             pwrite_i,
    input  wire [`FAS_APB_AW-1:0]           paddr_i,
    input  wire fas_regs_pkg::apb_data_t    pwdata_i,
    output fas_regs_pkg::apb_data_t         prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    input  wire                             data_valid_i,
    input  wire fir_pkg::sample_t           data_i,
    output fir_pkg::sample_t                fir_d_o,
    output logic                            fir_valid_o
);

    import fir_pkg::*;

    coef_bank_t coef;
    logic       enable;
    taps_t      taps;
    logic       tap_strobe;

    // register block steers the filter
    fir_coef_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .coef_o       (coef),
        .enable_o     (enable)
    );

    fir_delay_line u_line (
        .clk          (clk),
        .rst          (rst),
        .enable_i     (enable),
        .data_valid_i (data_valid_i),
        .data_i       (data_i),
        .taps_o       (taps),
        .tap_strobe_o (tap_strobe)
    );

    fir_mac u_mac (
        .clk          (clk),
        .rst          (rst),
        .taps_i       (taps),
        .tap_strobe_i (tap_strobe),
        .coef_i       (coef),
        .fir_d_o      (fir_d_o),
        .fir_valid_o  (fir_valid_o)
    );

endmodule

`default_nettype wire

//--- fir/fir_coef_regs.sv
`default_nettype none

`include "fas_macros.svh"

module fir_coef_regs (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             psel_i,
    input  wire                             penable_i,
    input  wire                             pwrite_i,
    input  wire [`FAS_APB_AW-1:0]           paddr_i,
    input  wire fas_regs_pkg::apb_data_t    pwdata_i,
    output fas_regs_pkg::apb_data_t         prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    output fir_pkg::coef_bank_t             coef_o,
    output logic                            enable_o
);

    import fir_pkg::*;
    import fas_regs_pkg::*;

    localparam int IDX_W = $clog2(`FAS_HALF_TAPS);
    localparam logic [`FAS_APB_AW-1:0] COEF_SPAN = `FAS_APB_AW'(4 * `FAS_HALF_TAPS);

    logic                   access;
    logic [`FAS_APB_AW-1:0] coef_off;
    logic                   hit_coef;
    logic                   hit_ctrl;
    logic [IDX_W-1:0]       coef_idx;

    // access phase of a transfer
    assign access = psel_i && penable_i;

    // offsets below the base wrap and fail the span check
    assign coef_off = paddr_i - COEF_BASE;
    assign hit_coef = (coef_off < COEF_SPAN) && (coef_off[1:0] == 2'b00);
    assign hit_ctrl = (paddr_i == CTRL_ADDR);
    assign coef_idx = coef_off[IDX_W+1:2];

    // no wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access && !(hit_coef || hit_ctrl);

    always_ff @(posedge clk) begin
        if (rst) begin
            coef_o   <= '0;
            enable_o <= 1'b0;
        end else if (access && pwrite_i) begin
            if (hit_coef) begin
                coef_o[coef_idx] <= coef_t'(pwdata_i[`FAS_BW-1:0]);
            end
            if (hit_ctrl) begin
                enable_o <= pwdata_i[CTRL_EN_BIT];
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            if (hit_coef) begin
                // sign-extended to the bus width
                prdata_o = apb_data_t'(coef_o[coef_idx]);
            end else if (hit_ctrl) begin
                prdata_o[CTRL_EN_BIT] = enable_o;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        penable_i |-> psel_i)
        else $error("fir_coef_regs: penable_i without psel_i");

endmodule

`default_nettype wire

//--- fir/fir_mac.sv
`default_nettype none

`include "fas_macros.svh"

module fir_mac (
    input  wire                         clk,
    input  wire                         rst,
    input  wire fir_pkg::taps_t         taps_i,
    input  wire                         tap_strobe_i,
    input  wire fir_pkg::coef_bank_t    coef_i,
    output fir_pkg::sample_t            fir_d_o,
    output logic                        fir_valid_o
);

    import fir_pkg::*;

    presum_t [`FAS_HALF_TAPS-1:0] presum;
    acc_t                         acc;
    acc_t                         acc_shift;
    sample_t                      rounded;

    // pre-add mirrored taps, then one multiply per pair
    always_comb begin
        acc = '0;
        for (int k = 0; k < `FAS_HALF_TAPS; k++) begin
            presum[k] = presum_t'(taps_i[k]) + presum_t'(taps_i[`FAS_TAPS-1-k]);
            acc       = acc + acc_t'(presum[k]) * acc_t'(coef_i[k]);
        end
    end

    // neg plus one: arithmetic shift, then add the sign bit
    assign acc_shift = acc >>> `FAS_ZOOM;
    assign rounded   = acc_shift[`FAS_BW-1:0] + {{(`FAS_BW-1){1'b0}}, acc[`FAS_ACC_BW-1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            fir_valid_o <= 1'b0;
        end else begin
            fir_valid_o <= tap_strobe_i;
        end
    end

    always_ff @(posedge clk) begin
        if (tap_strobe_i) begin
            fir_d_o <= rounded;
        end
    end

endmodule

`default_nettype wire

//--- fir/fir_delay_line.sv
`default_nettype none

`include "fas_macros.svh"

module fir_delay_line (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     enable_i,
    input  wire                     data_valid_i,
    input  wire fir_pkg::sample_t   data_i,
    output fir_pkg::taps_t          taps_o,
    output logic                    tap_strobe_o
);

    localparam int CNT_W = $clog2(`FAS_TAPS) + 1;
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`FAS_TAPS);

    logic             accept;
    logic [CNT_W-1:0] fill_cnt;

    assign accept = enable_i && data_valid_i;

    // newest sample enters tap 0, oldest falls off tap 31
    always_ff @(posedge clk) begin
        if (accept) begin
            taps_o <= {taps_o[`FAS_TAPS-2:0], data_i};
        end
    end

    // warm-up count saturates once the line is full
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_cnt     <= '0;
            tap_strobe_o <= 1'b0;
        end else begin
            // this accept counts toward the fill
            tap_strobe_o <= accept && (fill_cnt >= CNT_FULL - 1'b1);
            if (accept && (fill_cnt != CNT_FULL)) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // an accepted sample must be fully defined
    assert property (@(posedge clk) disable iff (rst)
        accept |-> !$isunknown(data_i))
        else $error("fir_delay_line: unknown bits on data_i at accept");

endmodule

`default_nettype wire

//--- common/fas_regs_pkg.sv
`default_nettype none

`include "fas_macros.svh"

package fas_regs_pkg;

    typedef logic [`FAS_APB_DW-1:0] apb_data_t;

    // coefficient k lives at COEF_BASE + 4*k
    localparam logic [`FAS_APB_AW-1:0] COEF_BASE = 8'h00;

    localparam logic [`FAS_APB_AW-1:0] CTRL_ADDR = 8'h40;

    // gates sample intake
    localparam int CTRL_EN_BIT = 0;

endpackage

`default_nettype wire

//--- common/fir_pkg.sv
`default_nettype none

`include "fas_macros.svh"

package fir_pkg;

    typedef logic signed [`FAS_BW-1:0] sample_t;

    // Q0.16
    typedef logic signed [`FAS_BW-1:0] coef_t;

    // sum of a mirrored tap pair
    typedef logic signed [`FAS_BW:0] presum_t;

    typedef logic signed [`FAS_ACC_BW-1:0] acc_t;

    typedef coef_t [`FAS_HALF_TAPS-1:0] coef_bank_t;

    // tap 0 holds the newest sample
    typedef sample_t [`FAS_TAPS-1:0] taps_t;

endpackage

`default_nettype wire

//--- common/fas_macros.svh
`ifndef FAS_MACROS_SVH
`define FAS_MACROS_SVH

// sample width
`define FAS_BW 16

// filter length and unique coefficients of the symmetric FIR
`define FAS_TAPS 32
`define FAS_HALF_TAPS 16

// rounding shift back to sample width
`define FAS_ZOOM 16

// 17-bit pre-sum times 16-bit coef is 33 bits, sum of 16 adds 4
`define FAS_ACC_BW 37

// APB slave port
`define FAS_APB_AW 8
`define FAS_APB_DW 32

`endif
